// File: Makefile
# Verilator build and run of the packet router testbench

VERILATOR ?= verilator
TOP       ?= router_tb
FLIST     ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= NO ERRORS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "^$(PASS_MSG)$$" $(LOG); then \
		echo "test passed"; \
	else \
		echo "test failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: logic/data_switch.sv
/* data switch: input stage, destination decode and one output stage per port */

`timescale 1ns/1ps

module data_switch
    import switch_cfg_pkg::*, switch_types_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       cke,

    input  routed_beat_t               arb_beat,
    input  logic                       arb_valid,
    output logic                       arb_ready,

    output port_beat_t [num_port-1:0]  port_beat,
    output logic       [num_port-1:0]  port_valid,
    input  logic       [num_port-1:0]  port_ready
);

    routed_beat_t        sw_beat;      // beat held by the input stage
    logic                sw_valid;
    logic                sw_ready;

    port_beat_t          stage_beat;   // same tag and data offered to every port
    logic [num_port-1:0] stage_valid;
    logic [num_port-1:0] stage_ready;

    pipeline_reg #(.payload_t(routed_beat_t)) u_in_stage (
        .clk       (clk),
        .rst       (rst),
        .cke       (cke),
        .in_beat   (arb_beat),
        .in_valid  (arb_valid),
        .in_ready  (arb_ready),
        .out_beat  (sw_beat),
        .out_valid (sw_valid),
        .out_ready (sw_ready)
    );

    // ########################################################################
    // id decode, a stalled port holds the head beat
    // ########################################################################

    always_comb begin
        sw_ready    = 1'b0;
        stage_valid = '0;
        for (int j = 0; j < num_port; j++) begin
            if (sw_beat.id == id_width'(j)) begin
                sw_ready       = stage_ready[j];
                stage_valid[j] = sw_valid;
            end
        end
    end

    assign stage_beat.src  = sw_beat.src;
    assign stage_beat.data = sw_beat.data;

    for (genvar p = 0; p < num_port; p++) begin : g_port
        pipeline_reg #(.payload_t(port_beat_t)) u_out_stage (
            .clk       (clk),
            .rst       (rst),
            .cke       (cke),
            .in_beat   (stage_beat),
            .in_valid  (stage_valid[p]),
            .in_ready  (stage_ready[p]),
            .out_beat  (port_beat[p]),
            .out_valid (port_valid[p]),
            .out_ready (port_ready[p])
        );
    end

endmodule

// File: logic/pipeline_reg.sv
/* valid/ready register stage with a skid slot, payload type set by parameter */

`timescale 1ns/1ps

module pipeline_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     cke,

    input  payload_t in_beat,
    input  logic     in_valid,
    output logic     in_ready,

    output payload_t out_beat,
    output logic     out_valid,
    input  logic     out_ready
);

    logic     main_valid;          // main register holds a beat
    logic     skid_valid;          // skid register holds a beat
    logic     ready_q;             // registered copy of the skid slot being free
    payload_t main_beat;
    payload_t skid_beat;

    logic     in_fire;
    logic     main_load;

    assign in_fire   = in_valid & ready_q;
    assign main_load = ~main_valid | out_ready;  // main empties or drains this cycle

    // ########################################################################
    // control state
    // ########################################################################

    always_ff @(posedge clk) begin
        if (rst) begin
            main_valid <= 1'b0;
            skid_valid <= 1'b0;
            ready_q    <= 1'b1;
        end else if (cke) begin
            if (main_load) begin
                main_valid <= skid_valid | in_fire;  // skid first, else the new beat
                skid_valid <= 1'b0;
                ready_q    <= 1'b1;
            end else if (in_fire) begin
                skid_valid <= 1'b1;                  // output stalled, park the beat
                ready_q    <= 1'b0;
            end
        end
    end

    // payload registers follow the control decisions above
    always_ff @(posedge clk) begin
        if (cke) begin
            if (main_load) begin
                main_beat <= skid_valid ? skid_beat : in_beat;
            end
            if (!main_load && in_fire) begin
                skid_beat <= in_beat;
            end
        end
    end

    assign in_ready  = ready_q;
    assign out_valid = main_valid;
    assign out_beat  = main_beat;

endmodule

// File: logic/router_top.sv
/* packet router top: source arbiter feeding the data switch */

`timescale 1ns/1ps

module router_top
    import switch_cfg_pkg::*, switch_types_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       cke,

    input  src_beat_t  [num_src-1:0]   src_beat,
    input  logic       [num_src-1:0]   src_valid,
    output logic       [num_src-1:0]   src_ready,

    output port_beat_t [num_port-1:0]  port_beat,
    output logic       [num_port-1:0]  port_valid,
    input  logic       [num_port-1:0]  port_ready
);

    routed_beat_t arb_beat;    // merged stream into the switch
    logic         arb_valid;
    logic         arb_ready;   // registered ready of the switch input stage

    source_arbiter u_arbiter (
        .clk       (clk),
        .rst       (rst),
        .cke       (cke),
        .src_beat  (src_beat),
        .src_valid (src_valid),
        .src_ready (src_ready),
        .arb_beat  (arb_beat),
        .arb_valid (arb_valid),
        .arb_ready (arb_ready)
    );

    data_switch u_switch (
        .clk        (clk),
        .rst        (rst),
        .cke        (cke),
        .arb_beat   (arb_beat),
        .arb_valid  (arb_valid),
        .arb_ready  (arb_ready),
        .port_beat  (port_beat),
        .port_valid (port_valid),
        .port_ready (port_ready)
    );

endmodule

// File: logic/source_arbiter.sv
/* round-robin arbiter merging the source beats onto one stream, tagged with the origin */

`timescale 1ns/1ps

module source_arbiter
    import switch_cfg_pkg::*, switch_types_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      cke,

    input  src_beat_t [num_src-1:0]   src_beat,
    input  logic      [num_src-1:0]   src_valid,
    output logic      [num_src-1:0]   src_ready,

    output routed_beat_t              arb_beat,
    output logic                      arb_valid,
    input  logic                      arb_ready
);

    logic [src_width-1:0] ptr;     // source with the highest priority
    logic [src_width-1:0] scan;    // candidate walked during the search
    logic [src_width-1:0] grant;   // winning source this cycle
    logic                 found;   // some source is valid

    // next index, wrapping at num_src rather than at a power of two
    function automatic logic [src_width-1:0] wrap_inc(input logic [src_width-1:0] v);
        if (v == src_width'(num_src - 1)) begin
            return '0;
        end
        return v + 1'b1;
    endfunction

    // ########################################################################
    // grant search, starting at the pointer
    // ########################################################################

    always_comb begin
        scan  = ptr;
        grant = ptr;
        found = 1'b0;
        for (int i = 0; i < num_src; i++) begin
            if (!found && src_valid[scan]) begin
                grant = scan;
                found = 1'b1;
            end
            scan = wrap_inc(scan);
        end
    end

    always_comb begin
        arb_beat.id   = src_beat[grant].id;
        arb_beat.src  = grant;
        arb_beat.data = src_beat[grant].data;
    end

    assign arb_valid = found;

    always_comb begin
        src_ready = '0;
        if (found) begin
            src_ready[grant] = arb_ready;  // only the winner sees ready
        end
    end

    // pointer moves past the winner on every accepted beat
    always_ff @(posedge clk) begin
        if (rst) begin
            ptr <= '0;
        end else if (cke && found && arb_ready) begin
            ptr <= wrap_inc(grant);
        end
    end

endmodule

// File: logic/switch_cfg_pkg.sv
/* sizing constants for the packet router: sources, ports, id, tag and payload widths */

package switch_cfg_pkg;

    // ########################################################################
    // router dimensions
    // ########################################################################

    localparam int num_src    = 3;                 // peer sources sharing the switch input
    localparam int num_port   = 4;                 // output ports behind the switch

    // ########################################################################
    // field widths
    // ########################################################################

    localparam int id_width   = $clog2(num_port);  // destination id selects one port
    localparam int data_width = 16;                // payload carried by every beat
    localparam int src_width  = $clog2(num_src);   // origin tag added by the arbiter

endpackage

// File: logic/switch_types_pkg.sv
/* beat formats along the router path: source beat, routed beat, delivered port beat */

package switch_types_pkg;

    import switch_cfg_pkg::*;

    // offered by a source, before arbitration
    typedef struct packed {
        logic [id_width-1:0]   id;     // destination port
        logic [data_width-1:0] data;
    } src_beat_t;

    // on the arbiter to switch link
    typedef struct packed {
        logic [id_width-1:0]   id;     // destination port
        logic [src_width-1:0]  src;    // index of the winning source
        logic [data_width-1:0] data;
    } routed_beat_t;

    // delivered at a port; the port number stands for the id
    typedef struct packed {
        logic [src_width-1:0]  src;    // origin of the beat
        logic [data_width-1:0] data;
    } port_beat_t;

endpackage

// File: sim.f
logic/switch_cfg_pkg.sv
logic/switch_types_pkg.sv
logic/pipeline_reg.sv
logic/source_arbiter.sv
logic/data_switch.sv
logic/router_top.sv
test/router_assertions.sv
test/router_tb.sv

// File: test/router_assertions.sv
/* handshake assertions on the router top-level ports, bound into router_top */

`timescale 1ns/1ps

module router_assertions
    import switch_cfg_pkg::*, switch_types_pkg::*;
(
    input logic                       clk,
    input logic                       rst,
    input logic                       cke,
    input src_beat_t  [num_src-1:0]   src_beat,
    input logic       [num_src-1:0]   src_valid,
    input logic       [num_src-1:0]   src_ready,
    input port_beat_t [num_port-1:0]  port_beat,
    input logic       [num_port-1:0]  port_valid,
    input logic       [num_port-1:0]  port_ready
);

    int fail_count = 0;   // read by the testbench at the end of the run

    // ########################################################################
    // beat held until it transfers
    // ########################################################################

    for (genvar s = 0; s < num_src; s++) begin : g_src
        a_src_hold: assert property (@(posedge clk) disable iff (rst)
            src_valid[s] && !(src_ready[s] && cke) |=> src_valid[s] && $stable(src_beat[s]))
            else begin
                $error("source %0d dropped valid or changed its beat before transfer", s);
                fail_count++;
            end
    end

    for (genvar p = 0; p < num_port; p++) begin : g_port
        a_port_hold: assert property (@(posedge clk) disable iff (rst)
            port_valid[p] && !(port_ready[p] && cke) |=> port_valid[p] && $stable(port_beat[p]))
            else begin
                $error("port %0d dropped valid or changed its beat before transfer", p);
                fail_count++;
            end
    end

    a_reset_idle: assert property (@(posedge clk) rst |=> port_valid == '0)
        else begin
            $error("port_valid high while in reset");
            fail_count++;
        end

    a_one_grant: assert property (@(posedge clk) disable iff (rst) $onehot0(src_ready))
        else begin
            $error("more than one src_ready high");
            fail_count++;
        end

endmodule

bind router_top router_assertions u_assertions (
    .clk        (clk),
    .rst        (rst),
    .cke        (cke),
    .src_beat   (src_beat),
    .src_valid  (src_valid),
    .src_ready  (src_ready),
    .port_beat  (port_beat),
    .port_valid (port_valid),
    .port_ready (port_ready)
);

// File: test/router_tb.sv
/* router testbench: clock, reset, random traffic, queue model, checks and watchdog */

`timescale 1ns/1ps

module router_tb
    import switch_cfg_pkg::*, switch_types_pkg::*;
();

    localparam int clk_period    = 20;
    localparam int reset_cycles  = 8;
    localparam int beats_per_src = 200;  // random phase quota per source
    localparam int fair_cycles   = 90;   // length of the saturated phase
    localparam int total_beats   = num_src * beats_per_src + fair_cycles;
    localparam int drain_limit   = 40;   // cycles allowed to empty the pipeline

    logic                      clk;
    logic                      rst;
    logic                      cke;
    src_beat_t  [num_src-1:0]  src_beat;
    logic       [num_src-1:0]  src_valid;
    logic       [num_src-1:0]  src_ready;
    port_beat_t [num_port-1:0] port_beat;
    logic       [num_port-1:0] port_valid;
    logic       [num_port-1:0] port_ready;

    int                 seed;
    int                 mismatch_count = 0;
    int                 other_count = 0;
    int                 issued [num_src];
    int                 fair_count [num_src] = '{default: 0};
    int                 wait_cycles;
    int                 fair_min;
    int                 fair_max;
    logic [num_src-1:0] taken;       // source beats accepted at the last rising edge
    logic               fair_phase;

    // expected data per source and port pair, index src * num_port + port
    logic [data_width-1:0] expect_q [num_src*num_port][$];

    router_top DUT (
        .clk        (clk),
        .rst        (rst),
        .cke        (cke),
        .src_beat   (src_beat),
        .src_valid  (src_valid),
        .src_ready  (src_ready),
        .port_beat  (port_beat),
        .port_valid (port_valid),
        .port_ready (port_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #(total_beats * 40 * clk_period);
        $display("Timeout: the run did not finish at %0t", $time);
        $display("ERRORS FOUND");
        $finish;
    end

    // ########################################################################
    // reference model, updated where beats transfer
    // ########################################################################

    task automatic record_source(input int s);
        expect_q[s * num_port + int'(src_beat[s].id)].push_back(src_beat[s].data);
        taken[s] = 1'b1;
        if (fair_phase) begin
            fair_count[s]++;
        end
    endtask

    task automatic check_delivery(input int p);
        int                    s;
        int                    idx;
        logic [data_width-1:0] want;
        s = int'(port_beat[p].src);
        if (s >= num_src) begin
            $display("Error at %0t: port %0d delivered a beat with unknown source tag %0d",
                     $time, p, s);
            other_count++;
            return;
        end
        idx = s * num_port + p;
        if (expect_q[idx].size() == 0) begin
            $display("Error at %0t: port %0d delivered a beat from source %0d never sent there",
                     $time, p, s);
            other_count++;
            return;
        end
        want = expect_q[idx].pop_front();
        if (port_beat[p].data !== want) begin
            $display("Mismatch at %0t: port %0d source %0d data %h, expected %h",
                     $time, p, s, port_beat[p].data, want);
            mismatch_count++;
        end
    endtask

    always @(posedge clk) begin
        taken = '0;
        if (!rst && cke) begin
            for (int s = 0; s < num_src; s++) begin
                if (src_valid[s] && src_ready[s]) begin
                    record_source(s);
                end
            end
            for (int p = 0; p < num_port; p++) begin
                if (port_valid[p] && port_ready[p]) begin
                    check_delivery(p);
                end
            end
        end
    end

    // ########################################################################
    // stimulus, applied on the falling edge
    // ########################################################################

    task automatic drive_sources(input bit saturate);
        int r;
        for (int s = 0; s < num_src; s++) begin
            if (taken[s]) begin
                src_valid[s] = 1'b0;                  // beat went through
            end
            r = $random(seed);
            if (!src_valid[s] && (saturate || (issued[s] < beats_per_src && r[0]))) begin
                r = $random(seed);
                src_beat[s].id = r[id_width-1:0];
                r = $random(seed);
                src_beat[s].data = r[data_width-1:0];
                src_valid[s] = 1'b1;
                if (!saturate) begin
                    issued[s]++;
                end
            end
        end
    endtask

    task automatic retire_sources();
        for (int s = 0; s < num_src; s++) begin
            if (taken[s]) begin
                src_valid[s] = 1'b0;
            end
        end
    endtask

    task automatic drive_ports(input bit all_ready);
        int r;
        for (int p = 0; p < num_port; p++) begin
            r = $random(seed);
            port_ready[p] = all_ready | r[0];         // 50 % back-pressure otherwise
        end
    endtask

    function automatic bit sources_done();
        for (int s = 0; s < num_src; s++) begin
            if (issued[s] < beats_per_src) begin
                return 1'b0;
            end
        end
        return src_valid == '0;
    endfunction

    function automatic int queued_beats();
        int n;
        n = 0;
        for (int i = 0; i < num_src * num_port; i++) begin
            n += expect_q[i].size();
        end
        return n;
    endfunction

    initial begin
        int r;
        seed       = 73671;
        rst        = 1'b1;
        cke        = 1'b1;
        src_valid  = '0;
        src_beat   = '0;
        port_ready = '0;
        fair_phase = 1'b0;
        for (int s = 0; s < num_src; s++) begin
            issued[s] = 0;
        end

        repeat (reset_cycles) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        if (port_valid !== '0) begin
            $display("Mismatch at %0t: port_valid is %b after reset release", $time, port_valid);
            mismatch_count++;
        end

        // random traffic with back-pressure and clock enable gaps
        forever begin
            drive_sources(1'b0);
            if (sources_done()) begin
                break;
            end
            drive_ports(1'b0);
            r = $random(seed);
            cke = (r[2:0] != 3'd0);
            @(negedge clk);
        end

        // saturated phase, every source valid and every port ready
        cke = 1'b1;
        drive_ports(1'b1);
        fair_phase = 1'b1;
        repeat (fair_cycles) begin
            drive_sources(1'b1);
            @(negedge clk);
        end
        fair_phase = 1'b0;

        wait_cycles = 0;
        retire_sources();
        while ((src_valid != '0 || port_valid != '0 || queued_beats() != 0)
               && wait_cycles < drain_limit) begin
            @(negedge clk);
            retire_sources();
            wait_cycles++;
        end

        for (int i = 0; i < num_src * num_port; i++) begin
            if (expect_q[i].size() != 0) begin
                $display("Error: %0d beats from source %0d to port %0d never arrived",
                         expect_q[i].size(), i / num_port, i % num_port);
                other_count++;
            end
        end

        fair_min = fair_count[0];
        fair_max = fair_count[0];
        for (int s = 1; s < num_src; s++) begin
            fair_min = (fair_count[s] < fair_min) ? fair_count[s] : fair_min;
            fair_max = (fair_count[s] > fair_max) ? fair_count[s] : fair_max;
        end
        if (fair_max - fair_min > 1 || fair_min == 0) begin
            $display("Mismatch at %0t: saturated phase grants range from %0d to %0d",
                     $time, fair_min, fair_max);
            mismatch_count++;
        end

        $display("Checks done: %0d mismatches, %0d other errors, %0d assertion failures",
                 mismatch_count, other_count, DUT.u_assertions.fail_count);
        if (mismatch_count + other_count + DUT.u_assertions.fail_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
